/* logic/cnn_ctrl_pkg.sv */
// CNN engine control definitions
package cnn_ctrl_pkg;

	// Parallel MAC lanes in the array
	localparam int LANES = 8;
	localparam int LANE_W = $clog2(LANES);

	// Products accumulated per lane in one operation
	localparam int CNT_W = 16;

	// Total FIFO words of one operation, LANES times the count
	localparam int TOT_W = CNT_W + LANE_W;

	// Operation codes carried with start
	typedef enum logic [1:0] {
		OP_ACC  = 2'd0,
		OP_RELU = 2'd1
	} op_t;

endpackage

/* logic/cnn_arith_pkg.sv */
// CNN arithmetic formats and lane traffic
package cnn_arith_pkg;

	// Fixed point data and weight width
	localparam int SAMPLE_W = 16;

	// Headroom for long accumulations
	localparam int ACC_W = 40;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [2*SAMPLE_W-1:0] prod_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	// One FIFO entry, data and weight paired
	typedef struct packed {
		sample_t data;
		sample_t weight;
	} fifo_word_t;

	// Word steered to a single lane
	typedef struct packed {
		logic       strobe;
		fifo_word_t word;
	} lane_in_t;

	// Serial write-back word
	typedef struct packed {
		logic [cnn_ctrl_pkg::LANE_W-1:0] lane;
		acc_t                            value;
	} wb_t;

endpackage

/* logic/cmac.sv */
// Multiply-accumulate lane
`timescale 1ns/1ps

module cmac (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           clear,
	input  cnn_arith_pkg::lane_in_t        lane_in,
	input  logic [cnn_ctrl_pkg::CNT_W-1:0] op_num,
	output cnn_arith_pkg::acc_t            lane_acc,
	output logic                           lane_done
);
	import cnn_arith_pkg::*;
	import cnn_ctrl_pkg::*;

	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	prod_t            product;

	// Signed 16x16 product, full width
	assign product = lane_in.word.data * lane_in.word.weight;
	assign count_next = count + 1'b1;

	// Product count and completion flag
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= '0;
			lane_done <= 1'b0;
		end else if (clear) begin
			count <= '0;
			lane_done <= 1'b0;
		end else if (lane_in.strobe) begin
			count <= count_next;
			// Done rises with the last accumulate
			if (count_next == op_num) begin
				lane_done <= 1'b1;
			end
		end
	end

	// Accumulator, sign extended product
	always_ff @(posedge clk) begin
		if (clear) begin
			lane_acc <= '0;
		end else if (lane_in.strobe) begin
			lane_acc <= lane_acc + acc_t'(product);
		end
	end

	// Dispatcher must stop feeding a lane once its count is reached
	a_no_strobe_after_done: assert property (
		@(posedge clk) disable iff (rst)
		lane_in.strobe |-> !lane_done
	) else $error("cmac: strobe while lane_done");

endmodule

/* logic/burst_dispatch.sv */
// Burst dispatcher from FIFO to MAC lanes
`timescale 1ns/1ps

module burst_dispatch (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           start,
	input  cnn_ctrl_pkg::op_t              op_type,
	input  logic [cnn_ctrl_pkg::CNT_W-1:0] op_num,
	input  logic                           empty,
	input  cnn_arith_pkg::fifo_word_t      fifo_data,
	output logic                           rd_en,
	output logic                           clear,
	output logic [cnn_ctrl_pkg::CNT_W-1:0] op_num_q,
	output cnn_ctrl_pkg::op_t              op_type_q,
	output cnn_arith_pkg::lane_in_t        lane_in [cnn_ctrl_pkg::LANES]
);
	import cnn_ctrl_pkg::*;
	import cnn_arith_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_WAIT
	} state_t;

	state_t            state;
	logic [TOT_W-1:0]  total;
	logic [TOT_W-1:0]  issued;
	logic              pending;
	logic [LANE_W-1:0] lane_idx;
	logic [LANES-1:0]  strobe_q;
	fifo_word_t        word_q;

	// Clear goes out in the start cycle itself
	assign clear = start && (state == ST_IDLE);

	// Words needed for this operation
	assign total = TOT_W'(op_num_q) * TOT_W'(LANES);

	// Read only when data is there and the total is not yet reached
	assign rd_en = (state == ST_FETCH) && !empty && (issued < total);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
			issued <= '0;
			pending <= 1'b0;
			lane_idx <= '0;
			op_num_q <= CNT_W'(1);
			op_type_q <= OP_ACC;
		end else begin
			// FIFO data shows up one cycle after the read
			pending <= rd_en;
			if (pending) begin
				if (lane_idx == LANE_W'(LANES - 1)) begin
					lane_idx <= '0;
				end else begin
					lane_idx <= lane_idx + 1'b1;
				end
			end
			case (state)
				ST_IDLE: begin
					if (start) begin
						// A zero count runs as one product
						op_num_q <= (op_num == '0) ? CNT_W'(1) : op_num;
						op_type_q <= op_type;
						issued <= '0;
						lane_idx <= '0;
						state <= ST_FETCH;
					end
				end
				ST_FETCH: begin
					if (rd_en) begin
						issued <= issued + 1'b1;
						if (issued + 1'b1 == total) begin
							state <= ST_WAIT;
						end
					end
				end
				ST_WAIT: begin
					// Last word has been taken in
					if (!pending) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// One-hot strobe toward the lane in turn
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			strobe_q <= '0;
		end else if (pending) begin
			strobe_q <= LANES'(1) << lane_idx;
		end else begin
			strobe_q <= '0;
		end
	end

	// One word register shared by all lanes
	always_ff @(posedge clk) begin
		if (pending) begin
			word_q <= fifo_data;
		end
	end

	for (genvar i = 0; i < LANES; i++) begin : g_lane_out
		assign lane_in[i] = '{strobe: strobe_q[i], word: word_q};
	end

	a_no_read_when_empty: assert property (
		@(posedge clk) disable iff (rst)
		rd_en |-> !empty
	) else $error("burst_dispatch: rd_en with empty");

	// Every lane got the same number of words once the last one is in
	a_lane_wrap: assert property (
		@(posedge clk) disable iff (rst)
		(state == ST_WAIT && !pending) |-> (lane_idx == '0)
	) else $error("burst_dispatch: words steered off the read total");

endmodule

/* logic/result_merge.sv */
// Lane result merger and write-back
`timescale 1ns/1ps

module result_merge (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             clear,
	input  logic [cnn_ctrl_pkg::LANES-1:0]   lane_done,
	input  cnn_arith_pkg::acc_t              lane_acc [cnn_ctrl_pkg::LANES],
	input  cnn_ctrl_pkg::op_t                op_type_q,
	output cnn_arith_pkg::wb_t               wb,
	output logic                             wb_valid,
	output logic                             done,
	output logic                             busy
);
	import cnn_ctrl_pkg::*;
	import cnn_arith_pkg::*;

	typedef enum logic [1:0] {
		MS_IDLE,
		MS_COLLECT,
		MS_WRITE,
		MS_DONE
	} mstate_t;

	mstate_t           state;
	logic [LANE_W-1:0] idx;
	logic              all_done;
	logic              emit;
	acc_t              sel_acc;
	acc_t              out_acc;

	assign all_done = &lane_done;

	// First word leaves right after the last lane finishes
	assign emit = ((state == MS_COLLECT) && all_done) || (state == MS_WRITE);

	assign sel_acc = lane_acc[idx];

	// ReLU clamps negative sums to zero
	assign out_acc = ((op_type_q == OP_RELU) && sel_acc[ACC_W-1]) ? '0 : sel_acc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= MS_IDLE;
			idx <= '0;
			busy <= 1'b0;
			wb_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			wb_valid <= emit;
			done <= 1'b0;
			if (emit) begin
				idx <= idx + 1'b1;
			end
			case (state)
				MS_IDLE: begin
					if (clear) begin
						busy <= 1'b1;
						idx <= '0;
						state <= MS_COLLECT;
					end
				end
				MS_COLLECT: begin
					if (all_done) begin
						state <= MS_WRITE;
					end
				end
				MS_WRITE: begin
					if (idx == LANE_W'(LANES - 1)) begin
						state <= MS_DONE;
					end
				end
				MS_DONE: begin
					// Busy drops together with done
					done <= 1'b1;
					busy <= 1'b0;
					state <= MS_IDLE;
				end
				default: state <= MS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			wb <= '{lane: idx, value: out_acc};
		end
	end

	a_wb_in_busy: assert property (
		@(posedge clk) disable iff (rst)
		wb_valid |-> busy
	) else $error("result_merge: wb_valid outside busy");

	// Done only right after the last write-back
	a_done_after_wb: assert property (
		@(posedge clk) disable iff (rst)
		done |-> $past(wb_valid) && !wb_valid
	) else $error("result_merge: done not after write-back");

endmodule

/* logic/conv_engine.sv */
// Convolution engine top level
`timescale 1ns/1ps

module conv_engine (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           start,
	input  cnn_ctrl_pkg::op_t              op_type,
	input  logic [cnn_ctrl_pkg::CNT_W-1:0] op_num,
	input  logic                           empty,
	input  cnn_arith_pkg::fifo_word_t      fifo_data,
	output logic                           rd_en,
	output cnn_arith_pkg::wb_t             wb,
	output logic                           wb_valid,
	output logic                           done,
	output logic                           busy
);
	import cnn_ctrl_pkg::*;
	import cnn_arith_pkg::*;

	logic             clear;
	logic [CNT_W-1:0] op_num_q;
	op_t              op_type_q;
	lane_in_t         lane_in [LANES];
	logic [LANES-1:0] lane_done;
	acc_t             lane_acc [LANES];

	// Start is ignored while an operation is in flight
	burst_dispatch u_burst_dispatch (
		.clk       (clk),
		.rst       (rst),
		.start     (start && !busy),
		.op_type   (op_type),
		.op_num    (op_num),
		.empty     (empty),
		.fifo_data (fifo_data),
		.rd_en     (rd_en),
		.clear     (clear),
		.op_num_q  (op_num_q),
		.op_type_q (op_type_q),
		.lane_in   (lane_in)
	);

	for (genvar g = 0; g < LANES; g++) begin : g_lane
		cmac u_cmac (
			.clk       (clk),
			.rst       (rst),
			.clear     (clear),
			.lane_in   (lane_in[g]),
			.op_num    (op_num_q),
			.lane_acc  (lane_acc[g]),
			.lane_done (lane_done[g])
		);
	end

	result_merge u_result_merge (
		.clk       (clk),
		.rst       (rst),
		.clear     (clear),
		.lane_done (lane_done),
		.lane_acc  (lane_acc),
		.op_type_q (op_type_q),
		.wb        (wb),
		.wb_valid  (wb_valid),
		.done      (done),
		.busy      (busy)
	);

endmodule

/* sim/tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst
);
	// 40 ns clock period
	localparam int HALF_PERIOD = 20;
	localparam int RST_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Reset held over the first cycles
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* sim/conv_engine_tb.sv */
// Convolution engine testbench
`timescale 1ns/1ps

module conv_engine_tb;
	import cnn_ctrl_pkg::*;
	import cnn_arith_pkg::*;

	typedef struct packed {
		op_t              op;
		logic [CNT_W-1:0] num;
		logic [7:0]       empty_pct;
	} case_t;

	localparam int NUM_CASES = 6;
	localparam int MARGIN = 600;

	// Operation, product count, chance of empty in percent
	localparam case_t CASES [NUM_CASES] = '{
		'{OP_ACC,  16'd1, 8'd0},
		'{OP_ACC,  16'd5, 8'd25},
		'{OP_RELU, 16'd5, 8'd25},
		'{OP_ACC,  16'd7, 8'd60},
		'{OP_RELU, 16'd3, 8'd60},
		'{OP_ACC,  16'd0, 8'd0}
	};

	logic             clk;
	logic             rst;
	logic             start;
	op_t              op_type;
	logic [CNT_W-1:0] op_num;
	logic             empty;
	fifo_word_t       fifo_data;
	logic             rd_en;
	wb_t              wb;
	logic             wb_valid;
	logic             done;
	logic             busy;

	logic [31:0]      rng_state;
	logic [7:0]       empty_pct;
	int               cur_total;
	fifo_word_t       handed [$];
	int               cycle_count;
	int               timeout_limit;

	tb_clk_gen u_clk_gen (
		.clk (clk),
		.rst (rst)
	);

	conv_engine u_conv_engine (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.op_type   (op_type),
		.op_num    (op_num),
		.empty     (empty),
		.fifo_data (fifo_data),
		.rd_en     (rd_en),
		.wb        (wb),
		.wb_valid  (wb_valid),
		.done      (done),
		.busy      (busy)
	);

	function automatic logic [31:0] xorshift_step(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Four cycles per FIFO word over all cases plus slack
	function automatic int timeout_cycles();
		int sum;
		int n;
		sum = 0;
		for (int i = 0; i < NUM_CASES; i++) begin
			n = (CASES[i].num == '0) ? 1 : int'(CASES[i].num);
			sum += LANES * n * 4;
		end
		return sum + MARGIN;
	endfunction

	task automatic check_equal(input longint actual, input longint expected, input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s (got %0d, expected %0d)",
				$time, what, actual, expected);
			$display("tests failed");
			$fatal(1, "mismatch");
		end
	endtask

	// FIFO model returning each word one cycle after rd_en
	always @(posedge clk) begin
		if (rd_en) begin
			check_equal(longint'(empty), 0, "rd_en high while empty");
			check_equal(longint'(handed.size() < cur_total), 1, "read past operation total");
			rng_state = xorshift_step(rng_state);
			fifo_data <= fifo_word_t'(rng_state);
			handed.push_back(fifo_word_t'(rng_state));
		end
		rng_state = xorshift_step(rng_state);
		empty <= (rng_state % 100) < 32'(empty_pct);
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > timeout_limit) begin
			$display("Timeout: run did not finish within %0d clock cycles", timeout_limit);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	task automatic run_case(input int idx);
		case_t      c;
		int         eff_num;
		int         got;
		int         stray;
		int         negatives;
		logic       prev_wb;
		logic       finished;
		acc_t       got_val [LANES];
		longint     exp_sum [LANES];
		fifo_word_t w;
		c = CASES[idx];
		eff_num = (c.num == '0) ? 1 : int'(c.num);
		cur_total = LANES * eff_num;
		handed.delete();
		empty_pct <= c.empty_pct;
		for (int i = 0; i < LANES; i++) begin
			exp_sum[i] = 0;
			got_val[i] = '0;
		end
		got = 0;
		stray = 0;
		prev_wb = 1'b0;
		finished = 1'b0;

		@(posedge clk);
		start <= 1'b1;
		op_type <= c.op;
		op_num <= c.num;
		@(posedge clk);
		start <= 1'b0;

		while (!finished) begin
			@(posedge clk);
			if (stray == 1) begin
				start <= 1'b0;
				stray = 2;
			end else if (stray == 0 && wb_valid) begin
				// Second start during write-back with the dispatcher already idle
				start <= 1'b1;
				op_type <= (c.op == OP_ACC) ? OP_RELU : OP_ACC;
				op_num <= c.num + 16'd3;
				stray = 1;
			end
			if (wb_valid) begin
				check_equal(longint'(got < LANES), 1, "more write-backs than lanes");
				check_equal(longint'(wb.lane), longint'(got), "write-back lane order");
				got_val[got] = wb.value;
				got++;
			end
			if (done) begin
				check_equal(longint'(prev_wb), 1, "done not one cycle after write-back");
				check_equal(longint'(got), LANES, "write-backs before done");
				check_equal(longint'(busy), 0, "busy high together with done");
				finished = 1'b1;
			end
			prev_wb = wb_valid;
		end

		// Exactly one done and no stray write-back
		repeat (4) begin
			@(posedge clk);
			check_equal(longint'(done), 0, "extra done pulse");
			check_equal(longint'(wb_valid), 0, "write-back after done");
		end

		check_equal(longint'(handed.size()), longint'(cur_total), "FIFO words read");
		// Word k belongs to lane k mod LANES
		for (int k = 0; k < handed.size(); k++) begin
			w = handed[k];
			exp_sum[k % LANES] += longint'($signed(w.data)) * longint'($signed(w.weight));
		end
		negatives = 0;
		for (int i = 0; i < LANES; i++) begin
			if (exp_sum[i] < 0) begin
				negatives++;
				if (c.op == OP_RELU) begin
					exp_sum[i] = 0;
				end
			end
			check_equal(longint'($signed(got_val[i])), exp_sum[i],
				$sformatf("case %0d lane %0d result", idx, i));
		end
		$display("case %0d: %0d words, %0d negative lane sums", idx, cur_total, negatives);
	endtask

	initial begin
		start = 1'b0;
		op_type = OP_ACC;
		op_num = '0;
		empty = 1'b1;
		fifo_data = '0;
		rng_state = 32'hd7ab002a;
		empty_pct = 8'd0;
		cur_total = 0;
		cycle_count = 0;
		timeout_limit = timeout_cycles();

		@(posedge clk);
		while (rst) @(posedge clk);
		// Idle outputs out of reset
		check_equal(longint'(rd_en), 0, "rd_en after reset");
		check_equal(longint'(wb_valid), 0, "wb_valid after reset");
		check_equal(longint'(done), 0, "done after reset");
		check_equal(longint'(busy), 0, "busy after reset");

		for (int idx = 0; idx < NUM_CASES; idx++) begin
			run_case(idx);
		end

		$display("all tests passed");
		$finish;
	end

endmodule

/* verilog.f */
logic/cnn_ctrl_pkg.sv
logic/cnn_arith_pkg.sv
logic/cmac.sv
logic/burst_dispatch.sv
logic/result_merge.sv
logic/conv_engine.sv
sim/tb_clk_gen.sv
sim/conv_engine_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= conv_engine_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
